// File: source/isaPkg.sv
// MIPS instruction fields and the opcode, funct and syscall codes used by the control unit
// Only the integer subset is listed. FP coprocessor codes are not decoded
`default_nettype none

package isaPkg;

   typedef logic [5:0] opcodeT;   // Instr[31:26]
   typedef logic [5:0] functT;    // Instr[5:0], R-type only
   typedef logic [5:0] sysCodeT;  // Low bits of $v0 at syscall

   // Primary opcodes
   localparam opcodeT opRType = 6'd0;  // Funct selects the operation
   localparam opcodeT opJ     = 6'd2;
   localparam opcodeT opJal   = 6'd3;
   localparam opcodeT opBeq   = 6'd4;
   localparam opcodeT opBne   = 6'd5;

   // Arithmetic immediates, sign extended
   localparam opcodeT opAddi  = 6'd8;
   localparam opcodeT opAddiu = 6'd9;
   localparam opcodeT opSlti  = 6'd10;
   localparam opcodeT opSltiu = 6'd11;

   // Logical immediates, zero extended
   localparam opcodeT opAndi  = 6'd12;
   localparam opcodeT opOri   = 6'd13;
   localparam opcodeT opXori  = 6'd14;
   localparam opcodeT opLui   = 6'd15;  // Grouped with arithmetic in the FSM

   // Word memory access
   localparam opcodeT opLw    = 6'd35;
   localparam opcodeT opSw    = 6'd43;

   // R-type functs that leave the plain ALU path
   localparam functT fnSll     = 6'd0;
   localparam functT fnSrl     = 6'd2;
   localparam functT fnSra     = 6'd3;
   localparam functT fnJr      = 6'd8;
   localparam functT fnSyscall = 6'd12;
   localparam functT fnMult    = 6'd24;  // Result goes to HI/LO, no writeback
   localparam functT fnDiv     = 6'd26;  // Same as mult

   // Syscall services
   // Any other code is treated as a print
   localparam sysCodeT sysPrintInt = 6'd1;
   localparam sysCodeT sysPrintStr = 6'd4;
   localparam sysCodeT sysPrintChr = 6'd11;
   localparam sysCodeT sysSleep    = 6'd32;  // Waits on external done pulse

endpackage

`default_nettype wire

// File: source/controlPkg.sv
// Control unit FSM states, instruction classes and datapath select widths
// State encodings match the existing datapath debug display, do not renumber
`default_nettype none

package controlPkg;

   // Multicycle FSM states
   // Gaps in the encoding are left from the removed FP and timer states
   typedef enum logic [5:0]
   {
      FETCH     = 6'd0,   // Shared by every instruction
      DECODE    = 6'd1,   // Shared, computes branch target
      MEMADDR   = 6'd2,   // Base plus offset
      MEMREAD   = 6'd3,
      LOADWB    = 6'd4,
      MEMWRITE  = 6'd5,
      RTYPE     = 6'd6,   // ALU op from funct
      RTYPEWB   = 6'd7,   // Write rd
      SHIFT     = 6'd8,   // Shamt on port A
      IMMLOGIC  = 6'd9,   // Zero extended immediate
      IMMARITH  = 6'd10,  // Sign extended immediate
      IMMWB     = 6'd11,  // Write rt
      BEQ       = 6'd12,
      BNE       = 6'd13,
      JUMP      = 6'd14,
      JAL       = 6'd15,
      JR        = 6'd16,
      PRINT     = 6'd32,
      SLEEP     = 6'd35,  // Loads sleep counter
      SLEEPWAIT = 6'd36,  // Idle until done pulse
      ERROR     = 6'd63   // Trap, left only by reset
   } stateT;

   // Instruction class as seen by the sequencer
   typedef enum logic [3:0]
   {
      clsLoad,
      clsStore,
      clsRType,
      clsMulDiv,    // R-type without writeback
      clsShift,
      clsImmLogic,
      clsImmArith,
      clsBeq,
      clsBne,
      clsJump,
      clsJal,
      clsJr,
      clsPrint,     // Syscall, any code but sleep
      clsSleep,
      clsIllegal
   } instrClassT;

   // Datapath select fields
   typedef logic [1:0] aluOpT;     // 0 add, 1 sub, 2 funct, 3 opcode
   typedef logic [1:0] aluSrcAT;   // 0 PC, 1 rs, 2 shamt
   typedef logic [2:0] aluSrcBT;   // 0 rt, 1 four, 2 sign imm, 3 branch off, 4 zero imm
   typedef logic [2:0] pcSourceT;  // 0 ALU, 1 ALUOut, 2 jump, 3 rs, 4 syscall return
   typedef logic [2:0] storeSelT;  // Write-back source, 3 is PC+4 or syscall data

endpackage

`default_nettype wire

// File: source/instrDecode.sv
// Combinational instruction classifier, inputs come straight from the IR
// Unknown opcodes give clsIllegal; unknown R-type functs run as plain ALU ops
`timescale 1ns/1ps
`default_nettype none

module instrDecode
(
   input  isaPkg::opcodeT         iOp,
   input  isaPkg::functT          iFunct,
   input  isaPkg::sysCodeT        iV0,
   output controlPkg::instrClassT instrClass
);

   always_comb
   begin
      instrClass = controlPkg::clsIllegal;  // Default for unknown opcodes
      case (iOp)
         isaPkg::opRType:
         begin
            // Order matters, first match wins
            if (iFunct == isaPkg::fnJr)
               instrClass = controlPkg::clsJr;
            else if (iFunct == isaPkg::fnSll || iFunct == isaPkg::fnSrl ||
                     iFunct == isaPkg::fnSra)
               instrClass = controlPkg::clsShift;
            else if (iFunct == isaPkg::fnSyscall)
            begin
               // Service picked by $v0
               if (iV0 == isaPkg::sysSleep)
                  instrClass = controlPkg::clsSleep;
               else
                  instrClass = controlPkg::clsPrint;  // Print services and unknown codes
            end
            else if (iFunct == isaPkg::fnMult || iFunct == isaPkg::fnDiv)
               instrClass = controlPkg::clsMulDiv;  // HI/LO only
            else
               instrClass = controlPkg::clsRType;
         end

         isaPkg::opJ:
            instrClass = controlPkg::clsJump;
         isaPkg::opJal:
            instrClass = controlPkg::clsJal;
         isaPkg::opBeq:
            instrClass = controlPkg::clsBeq;
         isaPkg::opBne:
            instrClass = controlPkg::clsBne;

         // Loads and stores share the address state
         isaPkg::opLw:
            instrClass = controlPkg::clsLoad;
         isaPkg::opSw:
            instrClass = controlPkg::clsStore;

         isaPkg::opAndi,
         isaPkg::opOri,
         isaPkg::opXori:
            instrClass = controlPkg::clsImmLogic;  // Zero extend path

         // Sign extend path, lui only uses the low half
         isaPkg::opAddi,
         isaPkg::opAddiu,
         isaPkg::opSlti,
         isaPkg::opSltiu,
         isaPkg::opLui:
            instrClass = controlPkg::clsImmArith;

         default:
            instrClass = controlPkg::clsIllegal;
      endcase
   end

endmodule

`default_nettype wire

// File: source/controlSequencer.sv
// State register and next-state logic of the multicycle FSM
// instrClass must stay stable from DECODE to the last state of the instruction
`timescale 1ns/1ps
`default_nettype none

module controlSequencer
(
   input  wire                    iCLK,
   input  wire                    iRST,
   input  controlPkg::instrClassT instrClass,
   input  wire                    iSleepDone,
   output controlPkg::stateT      state
);

   controlPkg::stateT nextState;

   // State register, one step per clock
   always_ff @(posedge iCLK)
   begin
      if (iRST)
         state <= controlPkg::FETCH;
      else
         state <= nextState;
   end

   always_comb
   begin
      nextState = controlPkg::ERROR;  // Unknown encodings trap
      case (state)
         controlPkg::FETCH:
            nextState = controlPkg::DECODE;

         controlPkg::DECODE:
         begin
            // Dispatch on instruction class
            case (instrClass)
               controlPkg::clsLoad,
               controlPkg::clsStore:
                  nextState = controlPkg::MEMADDR;
               controlPkg::clsRType,
               controlPkg::clsMulDiv:
                  nextState = controlPkg::RTYPE;  // Split again in RTYPE
               controlPkg::clsShift:
                  nextState = controlPkg::SHIFT;
               controlPkg::clsImmLogic:
                  nextState = controlPkg::IMMLOGIC;
               controlPkg::clsImmArith:
                  nextState = controlPkg::IMMARITH;
               controlPkg::clsBeq:
                  nextState = controlPkg::BEQ;
               controlPkg::clsBne:
                  nextState = controlPkg::BNE;
               controlPkg::clsJump:
                  nextState = controlPkg::JUMP;
               controlPkg::clsJal:
                  nextState = controlPkg::JAL;
               controlPkg::clsJr:
                  nextState = controlPkg::JR;
               controlPkg::clsPrint:
                  nextState = controlPkg::PRINT;
               controlPkg::clsSleep:
                  nextState = controlPkg::SLEEP;
               default:
                  nextState = controlPkg::ERROR;  // Illegal opcode
            endcase
         end

         controlPkg::MEMADDR:
         begin
            if (instrClass == controlPkg::clsLoad)
               nextState = controlPkg::MEMREAD;
            else if (instrClass == controlPkg::clsStore)
               nextState = controlPkg::MEMWRITE;
            else
               nextState = controlPkg::ERROR;  // IR changed under us
         end

         controlPkg::MEMREAD:
            nextState = controlPkg::LOADWB;

         // Mult and div have no register writeback
         controlPkg::RTYPE:
            nextState = (instrClass == controlPkg::clsMulDiv) ? controlPkg::FETCH
                                                              : controlPkg::RTYPEWB;

         controlPkg::SHIFT:
            nextState = controlPkg::RTYPEWB;  // Same writeback as R-type

         controlPkg::IMMLOGIC,
         controlPkg::IMMARITH:
            nextState = controlPkg::IMMWB;

         // Last state of their instruction
         controlPkg::LOADWB,
         controlPkg::MEMWRITE,
         controlPkg::RTYPEWB,
         controlPkg::IMMWB,
         controlPkg::BEQ,
         controlPkg::BNE,
         controlPkg::JUMP,
         controlPkg::JAL,
         controlPkg::JR,
         controlPkg::PRINT:
            nextState = controlPkg::FETCH;

         controlPkg::SLEEP:
            nextState = controlPkg::SLEEPWAIT;

         controlPkg::SLEEPWAIT:
            nextState = iSleepDone ? controlPkg::FETCH : controlPkg::SLEEPWAIT;

         controlPkg::ERROR:
            nextState = controlPkg::ERROR;  // Held until iRST

         default:
            nextState = controlPkg::ERROR;
      endcase
   end

endmodule

`default_nettype wire

// File: source/controlWord.sv
// Moore output decode, every control value depends on the state alone
// Strobes are levels held for the whole state; anything not listed is 0
`timescale 1ns/1ps
`default_nettype none

module controlWord
(
   input  controlPkg::stateT    state,
   output logic                 oIRWrite,
   output logic                 oMemtoReg,
   output logic                 oMemWrite,
   output logic                 oMemRead,
   output logic                 oIorD,
   output logic                 oPCWrite,
   output logic                 oPCWriteBEQ,
   output logic                 oPCWriteBNE,
   output logic                 oRegWrite,
   output logic                 oRegDst,
   output logic                 oSleepWrite,
   output controlPkg::aluOpT    oALUOp,
   output controlPkg::aluSrcAT  oALUSrcA,
   output controlPkg::aluSrcBT  oALUSrcB,
   output controlPkg::pcSourceT oPCSource,
   output controlPkg::storeSelT oStore,
   output controlPkg::stateT    oState
);

   assign oState = state;  // Debug display

   always_comb
   begin
      oIRWrite    = 1'b0;
      oMemtoReg   = 1'b0;
      oMemWrite   = 1'b0;
      oMemRead    = 1'b0;
      oIorD       = 1'b0;
      oPCWrite    = 1'b0;
      oPCWriteBEQ = 1'b0;
      oPCWriteBNE = 1'b0;
      oRegWrite   = 1'b0;
      oRegDst     = 1'b0;
      oSleepWrite = 1'b0;
      oALUOp      = 2'd0;
      oALUSrcA    = 2'd0;
      oALUSrcB    = 3'd0;
      oPCSource   = 3'd0;
      oStore      = 3'd0;
      case (state)
         controlPkg::FETCH:
         begin
            oMemRead = 1'b1;   // Instr at PC
            oIRWrite = 1'b1;
            oPCWrite = 1'b1;   // PC + 4 through ALU
            oALUSrcB = 3'd1;
         end
         controlPkg::DECODE:
            oALUSrcB = 3'd3;   // Branch target into ALUOut
         controlPkg::MEMADDR:
         begin
            oALUSrcA = 2'd1;
            oALUSrcB = 3'd2;   // rs + sign imm
         end
         controlPkg::MEMREAD:
         begin
            oMemRead = 1'b1;
            oIorD    = 1'b1;   // Address from ALUOut
         end
         controlPkg::LOADWB:
         begin
            oRegWrite = 1'b1;
            oMemtoReg = 1'b1;
         end
         controlPkg::MEMWRITE:
         begin
            oMemWrite = 1'b1;
            oIorD     = 1'b1;
         end
         controlPkg::RTYPE:
         begin
            oALUSrcA = 2'd1;
            oALUOp   = 2'd2;   // Funct decides
         end
         controlPkg::RTYPEWB:
         begin
            oRegWrite = 1'b1;
            oRegDst   = 1'b1;  // rd
         end
         controlPkg::SHIFT:
         begin
            oALUSrcA = 2'd2;   // Shamt
            oALUOp   = 2'd2;
         end
         controlPkg::IMMLOGIC:
         begin
            oALUSrcA = 2'd1;
            oALUSrcB = 3'd4;   // Zero extended
            oALUOp   = 2'd3;
         end
         controlPkg::IMMARITH:
         begin
            oALUSrcA = 2'd1;
            oALUSrcB = 3'd2;   // Sign extended
            oALUOp   = 2'd3;
         end
         controlPkg::IMMWB:
            oRegWrite = 1'b1;  // rt
         controlPkg::BEQ,
         controlPkg::BNE:
         begin
            // Subtract compare, target already in ALUOut
            oPCWriteBEQ = (state == controlPkg::BEQ);
            oPCWriteBNE = (state == controlPkg::BNE);
            oALUSrcA    = 2'd1;
            oALUOp      = 2'd1;
            oPCSource   = 3'd1;
         end
         controlPkg::JUMP:
         begin
            oPCWrite  = 1'b1;
            oPCSource = 3'd2;
         end
         controlPkg::JAL:
         begin
            oPCWrite  = 1'b1;
            oPCSource = 3'd2;
            oStore    = 3'd3;   // Return address to $ra
            oRegWrite = 1'b1;
         end
         controlPkg::JR:
         begin
            oPCWrite  = 1'b1;
            oPCSource = 3'd3;   // rs
         end
         controlPkg::PRINT:
         begin
            oStore    = 3'd3;
            oPCSource = 3'd4;
            oRegWrite = 1'b1;
         end
         controlPkg::SLEEP:
            oSleepWrite = 1'b1;  // One cycle, starts the timer
         controlPkg::ERROR:
            oRegDst = 1'b1;      // Trap marker
         default:
            oRegDst = 1'b0;      // SLEEPWAIT and unused codes stay idle
      endcase
   end

endmodule

`default_nettype wire

// File: source/multicycleControl.sv
// Multicycle control unit top, classifier, sequencer and output decode
// iOp, iFunct and iV0 must come from the IR and the register file, held per instr
`timescale 1ns/1ps
`default_nettype none

module multicycleControl
(
   input  wire                  iCLK,
   input  wire                  iRST,
   input  isaPkg::opcodeT       iOp,
   input  isaPkg::functT        iFunct,
   input  isaPkg::sysCodeT      iV0,
   input  wire                  iSleepDone,  // Sampled in SLEEPWAIT only
   output logic                 oIRWrite,
   output logic                 oMemtoReg,
   output logic                 oMemWrite,
   output logic                 oMemRead,
   output logic                 oIorD,
   output logic                 oPCWrite,
   output logic                 oPCWriteBEQ,
   output logic                 oPCWriteBNE,
   output logic                 oRegWrite,
   output logic                 oRegDst,
   output logic                 oSleepWrite,
   output controlPkg::aluOpT    oALUOp,
   output controlPkg::aluSrcAT  oALUSrcA,
   output controlPkg::aluSrcBT  oALUSrcB,
   output controlPkg::pcSourceT oPCSource,
   output controlPkg::storeSelT oStore,
   output controlPkg::stateT    oState
);

   controlPkg::instrClassT instrClass;
   controlPkg::stateT      state;

   instrDecode instrDecode0
   (
      .iOp        (iOp),
      .iFunct     (iFunct),
      .iV0        (iV0),
      .instrClass (instrClass)
   );

   controlSequencer controlSequencer0
   (
      .iCLK       (iCLK),
      .iRST       (iRST),
      .instrClass (instrClass),
      .iSleepDone (iSleepDone),
      .state      (state)
   );

   controlWord controlWord0
   (
      .state       (state),
      .oIRWrite    (oIRWrite),
      .oMemtoReg   (oMemtoReg),
      .oMemWrite   (oMemWrite),
      .oMemRead    (oMemRead),
      .oIorD       (oIorD),
      .oPCWrite    (oPCWrite),
      .oPCWriteBEQ (oPCWriteBEQ),
      .oPCWriteBNE (oPCWriteBNE),
      .oRegWrite   (oRegWrite),
      .oRegDst     (oRegDst),
      .oSleepWrite (oSleepWrite),
      .oALUOp      (oALUOp),
      .oALUSrcA    (oALUSrcA),
      .oALUSrcB    (oALUSrcB),
      .oPCSource   (oPCSource),
      .oStore      (oStore),
      .oState      (oState)
   );

endmodule

`default_nettype wire

// File: sim/tbMulticycleControl.sv
// Self-checking testbench, expected states and controls come from the per-state tables
// Instruction fields are driven in FETCH and held to the end of the instruction, as the IR is
`timescale 1ns/1ps
`default_nettype none

module tbMulticycleControl;

   localparam int maxCycles = 2000;  // About twice the length of all tests together

   logic                 iCLK;
   logic                 iRST;
   isaPkg::opcodeT       iOp;
   isaPkg::functT        iFunct;
   isaPkg::sysCodeT      iV0;
   logic                 iSleepDone;
   logic                 oIRWrite;
   logic                 oMemtoReg;
   logic                 oMemWrite;
   logic                 oMemRead;
   logic                 oIorD;
   logic                 oPCWrite;
   logic                 oPCWriteBEQ;
   logic                 oPCWriteBNE;
   logic                 oRegWrite;
   logic                 oRegDst;
   logic                 oSleepWrite;
   controlPkg::aluOpT    oALUOp;
   controlPkg::aluSrcAT  oALUSrcA;
   controlPkg::aluSrcBT  oALUSrcB;
   controlPkg::pcSourceT oPCSource;
   controlPkg::storeSelT oStore;
   controlPkg::stateT    oState;

   int                   errorCount;
   int                   checkCount;
   int                   testCount;
   int                   errorMark;   // Errors before the current test
   int                   cycleCount;
   logic [31:0]          rngState;
   controlPkg::stateT    expSeq[$];   // Expected states of one instruction

   // Opcode mix for the random stream, R-type weighted up
   isaPkg::opcodeT opPool [16] = '{
      isaPkg::opRType, isaPkg::opRType, isaPkg::opJ, isaPkg::opJal,
      isaPkg::opBeq, isaPkg::opBne, isaPkg::opAddi, isaPkg::opAddiu,
      isaPkg::opSlti, isaPkg::opSltiu, isaPkg::opAndi, isaPkg::opOri,
      isaPkg::opXori, isaPkg::opLui, isaPkg::opLw, isaPkg::opSw
   };
   // Special functs, syscall twice
   isaPkg::functT fnPool [8] = '{
      isaPkg::fnSll, isaPkg::fnSrl, isaPkg::fnSra, isaPkg::fnJr,
      isaPkg::fnSyscall, isaPkg::fnSyscall, isaPkg::fnMult, isaPkg::fnDiv
   };

   multicycleControl dut0
   (
      .iCLK        (iCLK),
      .iRST        (iRST),
      .iOp         (iOp),
      .iFunct      (iFunct),
      .iV0         (iV0),
      .iSleepDone  (iSleepDone),
      .oIRWrite    (oIRWrite),
      .oMemtoReg   (oMemtoReg),
      .oMemWrite   (oMemWrite),
      .oMemRead    (oMemRead),
      .oIorD       (oIorD),
      .oPCWrite    (oPCWrite),
      .oPCWriteBEQ (oPCWriteBEQ),
      .oPCWriteBNE (oPCWriteBNE),
      .oRegWrite   (oRegWrite),
      .oRegDst     (oRegDst),
      .oSleepWrite (oSleepWrite),
      .oALUOp      (oALUOp),
      .oALUSrcA    (oALUSrcA),
      .oALUSrcB    (oALUSrcB),
      .oPCSource   (oPCSource),
      .oStore      (oStore),
      .oState      (oState)
   );

   // 100 ns clock
   initial
   begin
      iCLK = 1'b0;
      forever #50 iCLK = ~iCLK;
   end

   // Watchdog on rising edges
   initial
   begin
      cycleCount = 0;
      while (cycleCount < maxCycles)
      begin
         @(posedge iCLK);
         cycleCount++;
      end
      $display("Timeout: run did not finish within %0d cycles", maxCycles);
      $display("*** TEST FAILED ***");
      $finish;
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   task automatic drawRandom(output logic [31:0] value);
      rngState = xorshift32(rngState);
      value    = rngState;
   endtask

   task automatic stepCycle();
      @(posedge iCLK);
      #10;  // Drive and sample well after the edge
   endtask

   task automatic checkValue(input string name, input int expected, input int actual);
      checkCount++;
      assert (actual == expected)
      else
      begin
         errorCount++;
         $display("** Error at time %0t ns: %s expected %0d, got %0d",
                  $time, name, expected, actual);
      end
   endtask

   // Control word per state, everything not listed is 0
   function automatic logic [23:0] expectedControls(input controlPkg::stateT s);
      logic [23:0] w;
      //    IR MtR MW MR IorD PCW BEQ BNE RW RD SW     op    srcA  srcB  pcSrc store
      case (s)
         controlPkg::FETCH:     w = {11'b1_0_0_1_0_1_0_0_0_0_0, 2'd0, 2'd0, 3'd1, 3'd0, 3'd0};
         controlPkg::DECODE:    w = {11'b0_0_0_0_0_0_0_0_0_0_0, 2'd0, 2'd0, 3'd3, 3'd0, 3'd0};
         controlPkg::MEMADDR:   w = {11'b0_0_0_0_0_0_0_0_0_0_0, 2'd0, 2'd1, 3'd2, 3'd0, 3'd0};
         controlPkg::MEMREAD:   w = {11'b0_0_0_1_1_0_0_0_0_0_0, 2'd0, 2'd0, 3'd0, 3'd0, 3'd0};
         controlPkg::LOADWB:    w = {11'b0_1_0_0_0_0_0_0_1_0_0, 2'd0, 2'd0, 3'd0, 3'd0, 3'd0};
         controlPkg::MEMWRITE:  w = {11'b0_0_1_0_1_0_0_0_0_0_0, 2'd0, 2'd0, 3'd0, 3'd0, 3'd0};
         controlPkg::RTYPE:     w = {11'b0_0_0_0_0_0_0_0_0_0_0, 2'd2, 2'd1, 3'd0, 3'd0, 3'd0};
         controlPkg::RTYPEWB:   w = {11'b0_0_0_0_0_0_0_0_1_1_0, 2'd0, 2'd0, 3'd0, 3'd0, 3'd0};
         controlPkg::SHIFT:     w = {11'b0_0_0_0_0_0_0_0_0_0_0, 2'd2, 2'd2, 3'd0, 3'd0, 3'd0};
         controlPkg::IMMLOGIC:  w = {11'b0_0_0_0_0_0_0_0_0_0_0, 2'd3, 2'd1, 3'd4, 3'd0, 3'd0};
         controlPkg::IMMARITH:  w = {11'b0_0_0_0_0_0_0_0_0_0_0, 2'd3, 2'd1, 3'd2, 3'd0, 3'd0};
         controlPkg::IMMWB:     w = {11'b0_0_0_0_0_0_0_0_1_0_0, 2'd0, 2'd0, 3'd0, 3'd0, 3'd0};
         controlPkg::BEQ:       w = {11'b0_0_0_0_0_0_1_0_0_0_0, 2'd1, 2'd1, 3'd0, 3'd1, 3'd0};
         controlPkg::BNE:       w = {11'b0_0_0_0_0_0_0_1_0_0_0, 2'd1, 2'd1, 3'd0, 3'd1, 3'd0};
         controlPkg::JUMP:      w = {11'b0_0_0_0_0_1_0_0_0_0_0, 2'd0, 2'd0, 3'd0, 3'd2, 3'd0};
         controlPkg::JAL:       w = {11'b0_0_0_0_0_1_0_0_1_0_0, 2'd0, 2'd0, 3'd0, 3'd2, 3'd3};
         controlPkg::JR:        w = {11'b0_0_0_0_0_1_0_0_0_0_0, 2'd0, 2'd0, 3'd0, 3'd3, 3'd0};
         controlPkg::PRINT:     w = {11'b0_0_0_0_0_0_0_0_1_0_0, 2'd0, 2'd0, 3'd0, 3'd4, 3'd3};
         controlPkg::SLEEP:     w = {11'b0_0_0_0_0_0_0_0_0_0_1, 2'd0, 2'd0, 3'd0, 3'd0, 3'd0};
         controlPkg::ERROR:     w = {11'b0_0_0_0_0_0_0_0_0_1_0, 2'd0, 2'd0, 3'd0, 3'd0, 3'd0};
         default:               w = '0;  // SLEEPWAIT
      endcase
      return w;
   endfunction

   // State and all 16 control outputs against the tables
   task automatic checkCycle(input controlPkg::stateT s);
      logic [23:0] w;
      w = expectedControls(s);
      checkValue("oState", int'(s), int'(oState));
      checkValue("oIRWrite", int'(w[23]), int'(oIRWrite));
      checkValue("oMemtoReg", int'(w[22]), int'(oMemtoReg));
      checkValue("oMemWrite", int'(w[21]), int'(oMemWrite));
      checkValue("oMemRead", int'(w[20]), int'(oMemRead));
      checkValue("oIorD", int'(w[19]), int'(oIorD));
      checkValue("oPCWrite", int'(w[18]), int'(oPCWrite));
      checkValue("oPCWriteBEQ", int'(w[17]), int'(oPCWriteBEQ));
      checkValue("oPCWriteBNE", int'(w[16]), int'(oPCWriteBNE));
      checkValue("oRegWrite", int'(w[15]), int'(oRegWrite));
      checkValue("oRegDst", int'(w[14]), int'(oRegDst));
      checkValue("oSleepWrite", int'(w[13]), int'(oSleepWrite));
      checkValue("oALUOp", int'(w[12:11]), int'(oALUOp));
      checkValue("oALUSrcA", int'(w[10:9]), int'(oALUSrcA));
      checkValue("oALUSrcB", int'(w[8:6]), int'(oALUSrcB));
      checkValue("oPCSource", int'(w[5:3]), int'(oPCSource));
      checkValue("oStore", int'(w[2:0]), int'(oStore));
   endtask

   // State walk of one instruction, FETCH up to its last state
   task automatic buildSequence(input isaPkg::opcodeT op, input isaPkg::functT fn,
                                input isaPkg::sysCodeT v0, input int hold);
      int k;
      expSeq.delete();
      expSeq.push_back(controlPkg::FETCH);
      expSeq.push_back(controlPkg::DECODE);
      case (op)
         isaPkg::opRType:
         begin
            if (fn == isaPkg::fnJr)
               expSeq.push_back(controlPkg::JR);
            else if (fn == isaPkg::fnSll || fn == isaPkg::fnSrl || fn == isaPkg::fnSra)
            begin
               expSeq.push_back(controlPkg::SHIFT);
               expSeq.push_back(controlPkg::RTYPEWB);
            end
            else if (fn == isaPkg::fnSyscall && v0 == isaPkg::sysSleep)
            begin
               expSeq.push_back(controlPkg::SLEEP);
               for (k = 0; k <= hold; k++)
                  expSeq.push_back(controlPkg::SLEEPWAIT);  // Last one sees done
            end
            else if (fn == isaPkg::fnSyscall)
               expSeq.push_back(controlPkg::PRINT);  // Any other service code
            else if (fn == isaPkg::fnMult || fn == isaPkg::fnDiv)
               expSeq.push_back(controlPkg::RTYPE);  // 3 cycles, no writeback
            else
            begin
               expSeq.push_back(controlPkg::RTYPE);
               expSeq.push_back(controlPkg::RTYPEWB);
            end
         end
         isaPkg::opLw:
         begin
            expSeq.push_back(controlPkg::MEMADDR);
            expSeq.push_back(controlPkg::MEMREAD);
            expSeq.push_back(controlPkg::LOADWB);
         end
         isaPkg::opSw:
         begin
            expSeq.push_back(controlPkg::MEMADDR);
            expSeq.push_back(controlPkg::MEMWRITE);
         end
         isaPkg::opAndi, isaPkg::opOri, isaPkg::opXori:
         begin
            expSeq.push_back(controlPkg::IMMLOGIC);
            expSeq.push_back(controlPkg::IMMWB);
         end
         isaPkg::opAddi, isaPkg::opAddiu, isaPkg::opSlti, isaPkg::opSltiu, isaPkg::opLui:
         begin
            expSeq.push_back(controlPkg::IMMARITH);
            expSeq.push_back(controlPkg::IMMWB);
         end
         isaPkg::opBeq:
            expSeq.push_back(controlPkg::BEQ);
         isaPkg::opBne:
            expSeq.push_back(controlPkg::BNE);
         isaPkg::opJ:
            expSeq.push_back(controlPkg::JUMP);
         isaPkg::opJal:
            expSeq.push_back(controlPkg::JAL);
         default:
            expSeq.push_back(controlPkg::ERROR);
      endcase
   endtask

   // Reset for 4 cycles, FETCH must hold throughout
   task automatic applyReset();
      iRST = 1'b1;
      repeat (4)
      begin
         stepCycle();
         checkCycle(controlPkg::FETCH);
      end
      iRST = 1'b0;
   endtask

   // Starts in FETCH, ends in the next FETCH or after a trap and reset
   task automatic runInstr(input isaPkg::opcodeT op, input isaPkg::functT fn,
                           input isaPkg::sysCodeT v0, input int hold);
      int i;
      int last;
      buildSequence(op, fn, v0, hold);
      last = expSeq.size() - 1;
      for (i = 0; i <= last; i++)
      begin
         if (i > 0)
            stepCycle();
         checkCycle(expSeq[i]);
         if (i == 0)
         begin
            iOp    = op;  // IR load
            iFunct = fn;
            iV0    = v0;
         end
         // High in SLEEP too, where it must be ignored
         iSleepDone = (expSeq[i] == controlPkg::SLEEP) ||
                      (expSeq[i] == controlPkg::SLEEPWAIT && i == last);
      end
      if (expSeq[last] == controlPkg::ERROR)
      begin
         repeat (3)
         begin
            stepCycle();
            checkCycle(controlPkg::ERROR);  // Trap holds
         end
         applyReset();
      end
      else
      begin
         stepCycle();
         iSleepDone = 1'b0;
         checkCycle(controlPkg::FETCH);
      end
   endtask

   task automatic finishTest(input string name);
      testCount++;
      $display("Test %0d %s finished, %0d errors", testCount, name, errorCount - errorMark);
      errorMark = errorCount;
   endtask

   initial
   begin
      int          n;
      logic [31:0] r;
      logic [31:0] h;
      iRST       = 1'b1;
      iOp        = '0;
      iFunct     = '0;
      iV0        = '0;
      iSleepDone = 1'b0;
      errorCount = 0;
      checkCount = 0;
      testCount  = 0;
      errorMark  = 0;
      rngState   = 32'd52;

      // Reset, FETCH controls, then DECODE
      applyReset();
      runInstr(isaPkg::opRType, 6'd32, 6'd0, 0);  // add
      finishTest("reset and fetch");

      runInstr(isaPkg::opLw, 6'd0, 6'd0, 0);
      runInstr(isaPkg::opSw, 6'd0, 6'd0, 0);
      runInstr(isaPkg::opRType, 6'd34, 6'd0, 0);  // sub
      runInstr(isaPkg::opRType, isaPkg::fnMult, 6'd0, 0);
      runInstr(isaPkg::opRType, isaPkg::fnDiv, 6'd0, 0);
      runInstr(isaPkg::opRType, isaPkg::fnSll, 6'd0, 0);
      runInstr(isaPkg::opRType, isaPkg::fnSrl, 6'd0, 0);
      runInstr(isaPkg::opRType, isaPkg::fnSra, 6'd0, 0);
      runInstr(isaPkg::opAndi, 6'd0, 6'd0, 0);
      runInstr(isaPkg::opOri, 6'd0, 6'd0, 0);
      runInstr(isaPkg::opXori, 6'd0, 6'd0, 0);
      runInstr(isaPkg::opAddi, 6'd0, 6'd0, 0);
      runInstr(isaPkg::opAddiu, 6'd0, 6'd0, 0);
      runInstr(isaPkg::opSlti, 6'd0, 6'd0, 0);
      runInstr(isaPkg::opSltiu, 6'd0, 6'd0, 0);
      runInstr(isaPkg::opLui, 6'd0, 6'd0, 0);
      runInstr(isaPkg::opJ, 6'd0, 6'd0, 0);
      runInstr(isaPkg::opRType, isaPkg::fnJr, 6'd0, 0);
      runInstr(isaPkg::opRType, isaPkg::fnSyscall, isaPkg::sysPrintInt, 0);
      finishTest("instruction classes");

      runInstr(isaPkg::opBeq, 6'd0, 6'd0, 0);
      runInstr(isaPkg::opBne, 6'd0, 6'd0, 0);
      runInstr(isaPkg::opJal, 6'd0, 6'd0, 0);
      runInstr(isaPkg::opRType, isaPkg::fnSyscall, isaPkg::sysPrintStr, 0);
      runInstr(isaPkg::opRType, isaPkg::fnSyscall, isaPkg::sysPrintChr, 0);
      finishTest("branch and link strobes");

      // Shortest and longest hold, then random ones
      runInstr(isaPkg::opRType, isaPkg::fnSyscall, isaPkg::sysSleep, 0);
      runInstr(isaPkg::opRType, isaPkg::fnSyscall, isaPkg::sysSleep, 15);
      repeat (4)
      begin
         drawRandom(r);
         runInstr(isaPkg::opRType, isaPkg::fnSyscall, isaPkg::sysSleep, int'(r[3:0]));
      end
      runInstr(isaPkg::opRType, isaPkg::fnSyscall, 6'd0, 0);   // Unknown codes print
      runInstr(isaPkg::opRType, isaPkg::fnSyscall, 6'd30, 0);
      runInstr(isaPkg::opRType, isaPkg::fnSyscall, 6'd63, 0);
      finishTest("sleep and syscall routing");

      runInstr(6'd1, 6'd0, 6'd0, 0);
      runInstr(6'd17, 6'd0, 6'd0, 0);  // COP1, not decoded
      runInstr(6'd49, 6'd0, 6'd0, 0);  // LWC1
      runInstr(6'd63, 6'd0, 6'd0, 0);
      runInstr(isaPkg::opRType, 6'd32, 6'd0, 0);  // Normal run after the trap
      finishTest("illegal opcode trap");

      for (n = 0; n < 150; n++)
      begin
         drawRandom(r);
         drawRandom(h);
         iSleepDone = 1'b0;
         runInstr((r[7:4] == 4'd0) ? r[13:8] : opPool[r[3:0]],  // 1 in 16 any opcode
                  r[17] ? r[23:18] : fnPool[r[16:14]],
                  r[24] ? isaPkg::sysSleep : r[30:25],
                  int'(h[3:0]));
      end
      finishTest("random instruction stream");

      $display("Summary: %0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
      if (errorCount == 0)
         $display("*** TEST PASSED ***");
      else
         $display("*** TEST FAILED ***");
      $finish;
   end

endmodule

`default_nettype wire

// File: sim.f
source/isaPkg.sv
source/controlPkg.sv
source/instrDecode.sv
source/controlSequencer.sv
source/controlWord.sv
source/multicycleControl.sv
sim/tbMulticycleControl.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tbMulticycleControl
FILELIST = sim.f
OBJDIR   = obj_dir
PASSMSG  = *** TEST PASSED ***

SOURCES  = $(wildcard source/*.sv) $(wildcard sim/*.sv)
EXE      = $(OBJDIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(EXE)

$(EXE): $(FILELIST) $(SOURCES)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# Fails unless the pass message shows up in the output
run: compile
	@out="$$(./$(EXE))"; echo "$$out"; echo "$$out" | grep -qF '$(PASSMSG)'

clean:
	rm -rf $(OBJDIR)
